//--- flist.f
+incdir+.
ooo_pkg.sv
issue_queue.sv
alu_unit.sv
mem_unit.sv
reorder_buffer.sv
ooo_core.sv
tb_clock_gen.sv
tb_checker.sv
tb_ooo_core.sv

//--- Makefile
# Verilator build and run of the out-of-order core testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  := All checks passed

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := ooo_config.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_ooo_core.sv
`timescale 1ns/100ps
`include "ooo_config.svh"

module tb_ooo_core import ooo_pkg::*; ();

    localparam int n_alu     = 200;
    localparam int n_store   = 40;
    localparam int n_load    = 60;
    localparam int n_exc     = 20;
    localparam int n_mix     = 150;
    localparam int total_ops = n_alu + n_store + n_load + 3 * n_exc + n_mix;
    localparam int watchdog_cycles = total_ops * 40;

    logic         clk;
    logic         rst;
    logic         dispatch_valid;
    dispatch_op_t dispatch_op;
    logic         dispatch_ready;
    logic         commit_valid;
    commit_t      commit;
    int           errors;
    int           accepted;
    int           committed;
    int           stalls;
    int           seed = 32'hbd50;
    int           failed_tests;

    tb_clock_gen clkgen0 (.clk(clk), .rst(rst));

    ooo_core dut0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_ready (dispatch_ready),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

    tb_checker chk0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_ready (dispatch_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .error_count    (errors),
        .accept_count   (accepted),
        .commit_count   (committed),
        .stall_count    (stalls)
    );

    function automatic dispatch_op_t make_alu();
        dispatch_op_t op;
        op        = '0;
        op.kind   = KIND_ALU;
        op.alu_op = alu_op_t'(3'($random(seed)));
        op.src_a  = $random(seed);
        op.src_b  = $random(seed);
        op.imm    = 16'($random(seed));
        op.rd     = 5'($random(seed));
        return op;
    endfunction

    // Base and offset are split at random so that the sum is the wanted address
    function automatic dispatch_op_t make_mem(logic store, logic [`XLEN-1:0] addr,
                                              logic [`XLEN-1:0] data);
        dispatch_op_t op;
        int           off;
        off         = $random(seed) % 8;
        op          = '0;
        op.kind     = KIND_MEM;
        op.alu_op   = ALU_ADD;
        op.is_store = store;
        op.imm      = 16'(off);
        op.src_a    = addr - 32'(off);
        op.src_b    = data;
        op.rd       = 5'($random(seed));
        return op;
    endfunction

    // Leaves valid high so that ops go back to back
    task automatic send_op(input dispatch_op_t op);
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        @(negedge clk);
        while (!dispatch_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        dispatch_valid = 1'b0;
        while (committed != accepted) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before, input int ops,
                               input bit cond_ok, input string note);
        int errs;
        errs = errors - errs_before;
        if (errs != 0 || !cond_ok) begin
            failed_tests++;
        end
        $display("Test %s: %0d ops, %0d errors %s -> %s", name, ops, errs, note,
                 (errs == 0 && cond_ok) ? "ok" : "FAILED");
    endtask

    initial begin
        int               errs_before;
        int               acc_before;
        int               stall_before;
        int               stall_cycles;
        logic [7:0]       k;
        logic [`XLEN-1:0] addr;
        dispatch_valid = 1'b0;
        dispatch_op    = '0;
        failed_tests   = 0;
        @(posedge clk);
        wait (!rst);
        repeat (2) @(posedge clk);
        #1;
        report_test("reset_state", 0, 0, 1'b1, "");

        errs_before = errors;
        repeat (n_alu) send_op(make_alu());
        drain();
        report_test("alu_random", errs_before, n_alu, 1'b1, "");

        // Loads reach twice the stored range so half of them hit unwritten words
        errs_before = errors;
        repeat (n_store) send_op(make_mem(1'b1, {26'b0, 6'($random(seed))}, $random(seed)));
        repeat (n_load) send_op(make_mem(1'b0, {25'b0, 7'($random(seed))}, '0));
        drain();
        report_test("store_load", errs_before, n_store + n_load, 1'b1, "");

        // A bad address aliasing word k must leave word k alone
        errs_before = errors;
        repeat (n_exc) begin
            k = 8'($random(seed));
            send_op(make_mem(1'b1, 32'd256 + 32'(k), $random(seed)));
            send_op(make_mem(1'b0, {24'hffffff, k}, '0));
            send_op(make_mem(1'b0, {24'b0, k}, '0));
        end
        drain();
        report_test("bad_address", errs_before, 3 * n_exc, 1'b1, "");

        errs_before  = errors;
        acc_before   = accepted;
        stall_before = stalls;
        repeat (n_mix) begin
            if ($random(seed) & 1) begin
                send_op(make_alu());
            end else begin
                addr = (($random(seed) % 16) == 0) ? 32'd300 : {27'b0, 5'($random(seed))};
                send_op(make_mem(1'(($random(seed))), addr, $random(seed)));
            end
        end
        drain();
        stall_cycles = stalls - stall_before;
        if (stall_cycles == 0) begin
            $display("Test mixed_stream never saw dispatch_ready low under a held valid");
        end
        report_test("mixed_stream", errs_before, accepted - acc_before, stall_cycles != 0,
                    $sformatf("(%0d stall cycles)", stall_cycles));

        $display("Summary: 5 tests, %0d failed, %0d dispatched, %0d committed, %0d errors",
                 failed_tests, accepted, committed, errors);
        if (errors == 0 && failed_tests == 0 && committed == accepted) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/100ps
`include "ooo_config.svh"

module tb_checker import ooo_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         dispatch_valid,
    input  dispatch_op_t dispatch_op,
    input  logic         dispatch_ready,
    input  logic         commit_valid,
    input  commit_t      commit,
    output int           error_count,
    output int           accept_count,
    output int           commit_count,
    output int           stall_count
);

    commit_t          expected_q [$];
    logic [`XLEN-1:0] model_mem [`MEM_WORDS];
    logic             reset_checked;

    function automatic logic [`XLEN-1:0] alu_result(alu_op_t op, logic [`XLEN-1:0] a,
                                                    logic [`XLEN-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    // Expected commit of one accepted operation, in program order
    task automatic predict(input dispatch_op_t op);
        commit_t          exp;
        logic [`XLEN-1:0] addr;
        logic             in_range;
        exp    = '0;
        exp.rd = op.rd;
        if (op.kind == KIND_ALU) begin
            exp.data      = alu_result(op.alu_op, op.src_a, op.src_b);
            exp.write_reg = 1'b1;
        end else begin
            addr          = op.src_a + {{(`XLEN-16){op.imm[15]}}, op.imm};
            in_range      = (addr < `MEM_WORDS);
            exp.exception = !in_range;
            if (op.is_store) begin
                if (in_range) begin
                    model_mem[addr[`MEM_ADDR_W-1:0]] = op.src_b;
                end
            end else if (in_range) begin
                exp.data      = model_mem[addr[`MEM_ADDR_W-1:0]];
                exp.write_reg = 1'b1;
            end
        end
        expected_q.push_back(exp);
    endtask

    task automatic compare_commit();
        commit_t exp;
        if (expected_q.size() == 0) begin
            $display("Error %0t: commit seen with no operation outstanding", $time);
            error_count++;
        end else begin
            exp = expected_q.pop_front();
            if (commit !== exp) begin
                $display("Error %0t: commit %0d got rd=%0d data=%h wr=%b exc=%b, %s",
                         $time, commit_count, commit.rd, commit.data, commit.write_reg,
                         commit.exception,
                         $sformatf("expected rd=%0d data=%h wr=%b exc=%b",
                                   exp.rd, exp.data, exp.write_reg, exp.exception));
                error_count++;
            end
        end
    endtask

    // Inputs and DUT state are settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                model_mem[i] = '0;
            end
            expected_q.delete();
            reset_checked = 1'b0;
            error_count   = 0;
            accept_count  = 0;
            commit_count  = 0;
            stall_count   = 0;
        end else begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!dispatch_ready || commit_valid) begin
                    $display("Error %0t: after reset dispatch_ready=%b commit_valid=%b",
                             $time, dispatch_ready, commit_valid);
                    error_count++;
                end
            end
            if (dispatch_valid && dispatch_ready) begin
                predict(dispatch_op);
                accept_count++;
            end else if (dispatch_valid) begin
                stall_count++;
            end
            if (commit_valid) begin
                compare_commit();
                commit_count++;
            end
        end
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release lands just after a rising edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- ooo_core.sv
`timescale 1ns/100ps

module ooo_core import ooo_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         dispatch_valid,
    input  dispatch_op_t dispatch_op,
    output logic         dispatch_ready,
    output logic         commit_valid,
    output commit_t      commit
);

    logic      alu_req_valid;
    alu_req_t  alu_req;
    logic      alu_ready;
    complete_t alu_done;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_ready;
    complete_t mem_done;

    reorder_buffer rob (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_ready (dispatch_ready),
        .alu_req_valid  (alu_req_valid),
        .alu_req        (alu_req),
        .alu_ready      (alu_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .alu_done       (alu_done),
        .mem_done       (mem_done),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

    // Integer and load/store units run side by side
    alu_unit alu0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (alu_req_valid),
        .req       (alu_req),
        .ready     (alu_ready),
        .done      (alu_done)
    );

    mem_unit mem0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .ready     (mem_ready),
        .done      (mem_done)
    );

endmodule

//--- reorder_buffer.sv
`timescale 1ns/100ps
`include "ooo_config.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         dispatch_valid,
    input  dispatch_op_t dispatch_op,
    output logic         dispatch_ready,
    output logic         alu_req_valid,
    output alu_req_t     alu_req,
    input  logic         alu_ready,
    output logic         mem_req_valid,
    output mem_req_t     mem_req,
    input  logic         mem_ready,
    input  complete_t    alu_done,
    input  complete_t    mem_done,
    output logic         commit_valid,
    output commit_t      commit
);

    typedef struct packed {
        logic [4:0]       rd;
        op_kind_t         kind;
        logic             is_store;
        logic [`XLEN-1:0] data;
        logic             exception;
    } rob_entry_t;

    rob_entry_t          entries [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_flags;
    logic [`TAG_W-1:0]   head;
    logic [`TAG_W-1:0]   tail;
    logic [`TAG_W:0]     count;
    logic                rob_full;
    logic                unit_ready;
    logic                fire;
    logic [`XLEN-1:0]    eff_addr;
    rob_entry_t          head_entry;

    assign rob_full   = (count == (`TAG_W+1)'(`ROB_DEPTH));
    assign unit_ready = (dispatch_op.kind == KIND_ALU) ? alu_ready : mem_ready;

    assign dispatch_ready = !rob_full && unit_ready;
    assign fire           = dispatch_valid && dispatch_ready;

    // The tail index becomes the tag of the steered request
    assign eff_addr = dispatch_op.src_a + {{(`XLEN-16){dispatch_op.imm[15]}}, dispatch_op.imm};

    assign alu_req_valid = fire && (dispatch_op.kind == KIND_ALU);
    assign mem_req_valid = fire && (dispatch_op.kind == KIND_MEM);

    assign alu_req = '{tag: tail, alu_op: dispatch_op.alu_op,
                       src_a: dispatch_op.src_a, src_b: dispatch_op.src_b};
    assign mem_req = '{tag: tail, is_store: dispatch_op.is_store,
                       addr: eff_addr, wdata: dispatch_op.src_b};

    // Retire the oldest entry once its result is back
    assign head_entry   = entries[head];
    assign commit_valid = (count != '0) && done_flags[head];
    assign commit = '{
        rd:        head_entry.rd,
        data:      head_entry.data,
        write_reg: !head_entry.exception &&
                   ((head_entry.kind == KIND_ALU) || !head_entry.is_store),
        exception: head_entry.exception
    };

    // Pointers wrap naturally since ROB_DEPTH is 2**TAG_W
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (fire) begin
                tail <= tail + 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + (`TAG_W+1)'(fire) - (`TAG_W+1)'(commit_valid);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_flags <= '0;
        end else begin
            if (fire) begin
                done_flags[tail] <= 1'b0;
            end
            if (alu_done.valid) begin
                done_flags[alu_done.tag] <= 1'b1;
            end
            if (mem_done.valid) begin
                done_flags[mem_done.tag] <= 1'b1;
            end
        end
    end

    // Both buses carry distinct tags, so the two writes never collide
    always_ff @(posedge clk) begin
        if (fire) begin
            entries[tail].rd       <= dispatch_op.rd;
            entries[tail].kind     <= dispatch_op.kind;
            entries[tail].is_store <= dispatch_op.is_store;
        end
        if (alu_done.valid) begin
            entries[alu_done.tag].data      <= alu_done.data;
            entries[alu_done.tag].exception <= alu_done.exception;
        end
        if (mem_done.valid) begin
            entries[mem_done.tag].data      <= mem_done.data;
            entries[mem_done.tag].exception <= mem_done.exception;
        end
    end

endmodule

//--- mem_unit.sv
`timescale 1ns/100ps
`include "ooo_config.svh"

module mem_unit import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      ready,
    output complete_t done
);

    mem_req_t               head;
    logic                   head_valid;
    logic                   take;
    logic                   acc_valid;
    mem_req_t               acc_req;
    logic                   in_range;
    logic [`MEM_ADDR_W-1:0] word_idx;
    logic [`XLEN-1:0]       mem [`MEM_WORDS];
    logic                   resp_valid;
    logic [`TAG_W-1:0]      resp_tag;
    logic [`XLEN-1:0]       resp_data;
    logic                   resp_exc;

    issue_queue #(
        .payload_t (mem_req_t),
        .depth     (`MEM_Q_DEPTH)
    ) req_q (
        .clk       (clk),
        .rst       (rst),
        .push      (req_valid),
        .push_data (req),
        .pop       (take),
        .pop_data  (head),
        .not_empty (head_valid),
        .not_full  (ready)
    );

    // Only one request may sit in the access stage
    assign take = head_valid && !acc_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc_req <= head;
        end
    end

    assign in_range = (acc_req.addr < `MEM_WORDS);
    assign word_idx = acc_req.addr[`MEM_ADDR_W-1:0];

    // Out-of-range stores leave the array untouched
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (acc_valid && acc_req.is_store && in_range) begin
            mem[word_idx] <= acc_req.wdata;
        end
    end

    // Respond stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            resp_tag  <= acc_req.tag;
            resp_exc  <= !in_range;
            // Stores and bad addresses return zero
            resp_data <= (in_range && !acc_req.is_store) ? mem[word_idx] : '0;
        end
    end

    assign done = '{valid: resp_valid, tag: resp_tag, data: resp_data, exception: resp_exc};

endmodule

//--- alu_unit.sv
`timescale 1ns/100ps
`include "ooo_config.svh"

module alu_unit import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  alu_req_t  req,
    output logic      ready,
    output complete_t done
);

    alu_req_t          head;
    logic              head_valid;
    logic [`XLEN-1:0]  result;
    logic              done_valid;
    logic [`TAG_W-1:0] done_tag;
    logic [`XLEN-1:0]  done_data;

    // The result register is free every cycle, so the head issues whenever present
    issue_queue #(
        .payload_t (alu_req_t),
        .depth     (`ALU_Q_DEPTH)
    ) req_q (
        .clk       (clk),
        .rst       (rst),
        .push      (req_valid),
        .push_data (req),
        .pop       (head_valid),
        .pop_data  (head),
        .not_empty (head_valid),
        .not_full  (ready)
    );

    always_comb begin
        result = '0;
        case (head.alu_op)
            ALU_ADD: result = head.src_a + head.src_b;
            ALU_SUB: result = head.src_a - head.src_b;
            ALU_AND: result = head.src_a & head.src_b;
            ALU_OR:  result = head.src_a | head.src_b;
            ALU_XOR: result = head.src_a ^ head.src_b;
            ALU_SLT: result[0] = ($signed(head.src_a) < $signed(head.src_b));
            // Shift amount is the low 5 bits of src_b
            ALU_SLL: result = head.src_a << head.src_b[4:0];
            ALU_SRL: result = head.src_a >> head.src_b[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_valid <= 1'b0;
        end else begin
            done_valid <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (head_valid) begin
            done_tag  <= head.tag;
            done_data <= result;
        end
    end

    // Integer ops never raise an exception
    assign done = '{valid: done_valid, tag: done_tag, data: done_data, exception: 1'b0};

endmodule

//--- issue_queue.sv
`timescale 1ns/100ps

module issue_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     not_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         slots [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign not_full  = (count != cnt_w'(depth));

    // Requests beyond capacity or from an empty queue are ignored
    assign do_push  = push && not_full;
    assign do_pop   = pop && not_empty;
    assign pop_data = slots[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

endmodule

//--- ooo_pkg.sv
package ooo_pkg;

`include "ooo_config.svh"

    // Target unit of a dispatched operation
    typedef enum logic {
        KIND_ALU = 1'b0,
        KIND_MEM = 1'b1
    } op_kind_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_t;

    // Decoded operation with operand values already resolved
    // For memory ops src_a is the base and src_b the store data
    typedef struct packed {
        op_kind_t          kind;
        alu_op_t           alu_op;
        logic              is_store;
        logic [`XLEN-1:0]  src_a;
        logic [`XLEN-1:0]  src_b;
        logic [15:0]       imm;
        logic [4:0]        rd;
    } dispatch_op_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        alu_op_t           alu_op;
        logic [`XLEN-1:0]  src_a;
        logic [`XLEN-1:0]  src_b;
    } alu_req_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic              is_store;
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  wdata;
    } mem_req_t;

    // One result on a completion bus
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  data;
        logic              exception;
    } complete_t;

    typedef struct packed {
        logic [4:0]        rd;
        logic [`XLEN-1:0]  data;
        logic              write_reg;
        logic              exception;
    } commit_t;

endpackage

//--- ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// Tags index the reorder buffer entries directly
`define ROB_DEPTH 8
`define TAG_W 3

// Request queues in front of each execution unit
`define ALU_Q_DEPTH 4
`define MEM_Q_DEPTH 4

// Word-addressed data memory
`define MEM_WORDS 256
`define MEM_ADDR_W 8

// Datapath width
`define XLEN 32

`endif
